// File: ch_est_defines.svh
`ifndef CH_EST_DEFINES_SVH
`define CH_EST_DEFINES_SVH

// nrs read address width
`define CE_NRS_ADDR_W 4

// pilot symbols read per slot
`define CE_SYMS_PER_PHASE 4

// demap columns holding pilots
`define CE_COL_0 4'd5
`define CE_COL_1 4'd6
`define CE_COL_2 4'd12
`define CE_COL_3 4'd13

// six 2-bit fields per output select sequence
`define CE_SEL_SEQ_LEN 12

// adder operand mux select
`define CE_SEL_W 3

`endif

// File: ch_est_pkg.sv
`include "ch_est_defines.svh"

package ch_est_pkg;

    // pilot phase fsm
    typedef enum logic [1:0] {
        idle       = 2'b00,
        mult_store = 2'b01,
        mult_add   = 2'b11
    } mult_state_t;

    // adder 1 steps, named after the operand pair
    typedef enum logic [3:0] {
        a1_idle    = 4'b0000,
        a1_e2      = 4'b0010,
        a1_2e2     = 4'b0011,
        a1_e2_2e3  = 4'b0001,
        a1_e2_2e4  = 4'b0100,
        a1_2e2_5e4 = 4'b0101,
        a1_2e3_e1  = 4'b1000,
        a1_2e3     = 4'b1100,
        a1_5e1_2e3 = 4'b1110
    } adder1_state_t;

    // adder 2 steps
    typedef enum logic [3:0] {
        a2_idle   = 4'b0000,
        a2_2e1_e3 = 4'b0001,
        a2_e1_2e3 = 4'b0011,
        a2_2e2_e3 = 4'b0010,
        a2_2e2_e4 = 4'b0100,
        a2_5e4    = 4'b0101,
        a2_4e4_e2 = 4'b0111,
        a2_e3     = 4'b1000,
        a2_4e1_e3 = 4'b1010,
        a2_5e1    = 4'b1011
    } adder2_state_t;

    // v_shift 0/3 -> shift_0, 1/4 -> shift_1, rest -> shift_2
    typedef enum logic [1:0] {
        shift_0 = 2'd0,
        shift_1 = 2'd1,
        shift_2 = 2'd2
    } shift_class_t;

    typedef logic [`CE_SEL_SEQ_LEN-1:0] sel_seq_t;

    // out mux sequences, low field plays first
    localparam sel_seq_t sel_seq_h1 [3] = '{
        12'b01_11_10_11_01_00,
        12'b10_11_01_00_01_01,
        12'b01_10_11_11_00_11
    };

    localparam sel_seq_t sel_seq_h2 [3] = '{
        12'b10_11_00_00_01_00,
        12'b00_10_11_10_10_01,
        12'b11_10_00_01_00_00
    };

endpackage

// File: ch_est_ifs.sv
`timescale 1ns/1ps

// ======================================================================
// pilot phase -> interpolation
// ======================================================================

interface est_if import ch_est_pkg::*; ();

    // one-cycle strobes in an add slot, per stored estimate
    logic         e1_ready;
    logic         e2_ready;
    logic         e3_ready;
    // decoded v_shift, steady over the slot
    shift_class_t shift_class;

    modport source (output e1_ready, e2_ready, e3_ready, shift_class);
    modport sink   (input  e1_ready, e2_ready, e3_ready, shift_class);

endinterface

// ======================================================================
// interpolation -> output select stage
// ======================================================================

interface out_ctl_if import ch_est_pkg::*; ();

    // load two cycles ahead of the valid window
    logic         load_sel;
    logic         valid_start;
    logic         valid_end;
    shift_class_t shift_class;

    modport source (output load_sel, valid_start, valid_end, shift_class);
    modport sink   (input  load_sel, valid_start, valid_end, shift_class);

endinterface

// File: slot_sequencer.sv
`timescale 1ns/1ps
`include "ch_est_defines.svh"

module slot_sequencer
    import ch_est_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      demap_ready,
    input  logic                      nrs_gen_ready,
    input  logic [2:0]                v_shift,
    output logic [3:0]                col,
    output logic [1:0]                nrs_index_addr,
    output logic [`CE_NRS_ADDR_W-1:0] rd_addr_nrs,
    output logic [1:0]                addr_mem,
    output logic                      demap_read,
    output logic                      mult_mem_en,
    output logic                      avg_mem_en,
    est_if.source                     est
);

    // nrs table holds two entries per pilot
    localparam logic [`CE_NRS_ADDR_W-1:0] nrs_step = 2;

    mult_state_t cs, ns;
    logic [1:0]  sym_cnt;
    logic        sym_done;
    logic        store_slot;
    logic [1:0]  col_idx;

    // ==================================================================
    // pilot phase fsm
    // ==================================================================

    assign sym_done = (sym_cnt == 2'(`CE_SYMS_PER_PHASE - 1));

    always_comb begin
        ns = cs;
        case (cs)
            // readiness only looked at while idle
            idle: begin
                if (demap_ready && nrs_gen_ready) begin
                    ns = store_slot ? mult_store : mult_add;
                end
            end
            mult_store, mult_add: begin
                if (sym_done) begin
                    ns = idle;
                end
            end
            default: ns = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cs             <= idle;
            sym_cnt        <= 2'd0;
            store_slot     <= 1'b1;
            col_idx        <= 2'd0;
            nrs_index_addr <= 2'd0;
            rd_addr_nrs    <= '0;
            mult_mem_en    <= 1'b0;
            avg_mem_en     <= 1'b0;
        end else begin
            cs          <= ns;
            // memory enables trail the reads by one cycle
            mult_mem_en <= (cs == mult_store);
            avg_mem_en  <= (cs == mult_add);
            if (demap_read) begin
                sym_cnt        <= sym_cnt + 2'd1;
                nrs_index_addr <= nrs_index_addr + 2'd1;
                rd_addr_nrs    <= rd_addr_nrs + nrs_step;
                // two reads per column
                if (sym_cnt[0]) begin
                    col_idx <= col_idx + 2'd1;
                end
                // store and add slots alternate
                if (sym_done) begin
                    store_slot <= ~store_slot;
                end
            end
        end
    end

    assign demap_read = (cs != idle);
    assign addr_mem   = sym_cnt;

    always_comb begin
        case (col_idx)
            2'd0: col = `CE_COL_0;
            2'd1: col = `CE_COL_1;
            2'd2: col = `CE_COL_2;
            2'd3: col = `CE_COL_3;
        endcase
    end

    // ==================================================================
    // interpolation triggers
    // ==================================================================

    assign est.e1_ready = (cs == mult_add) && (sym_cnt == 2'd0);
    assign est.e2_ready = (cs == mult_add) && (sym_cnt == 2'd1);
    assign est.e3_ready = (cs == mult_add) && (sym_cnt == 2'd2);

    always_comb begin
        case (v_shift)
            3'd0, 3'd3: est.shift_class = shift_0;
            3'd1, 3'd4: est.shift_class = shift_1;
            default:    est.shift_class = shift_2;
        endcase
    end

    // product and average memories never written together
    assert property (@(posedge clk) disable iff (!rst) !(mult_mem_en && avg_mem_en))
        else $error("mult_mem_en and avg_mem_en both high");

endmodule

// File: interp_sequencer.sv
`timescale 1ns/1ps
`include "ch_est_defines.svh"

module interp_sequencer
    import ch_est_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    est_if.sink                  est,
    out_ctl_if.source            octl,
    output logic [`CE_SEL_W-1:0] s1a,
    output logic [`CE_SEL_W-1:0] s1b,
    output logic [`CE_SEL_W-1:0] s2a,
    output logic [`CE_SEL_W-1:0] s2b,
    output logic                 en_reg_e,
    output logic                 en_reg_2e,
    output logic                 en_reg_5e
);

    adder1_state_t cs_a1, ns_a1;
    adder2_state_t cs_a2, ns_a2;
    shift_class_t  sc;
    // hold bits stretch a gated step to two cycles
    logic          hold_1, hold_2;
    logic          gate_1, gate_2;
    logic [2:0]    en_vec;

    assign sc = est.shift_class;

    // ==================================================================
    // adder fsms
    // ==================================================================

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cs_a1  <= a1_idle;
            cs_a2  <= a2_idle;
            hold_1 <= 1'b0;
            hold_2 <= 1'b0;
        end else begin
            cs_a1  <= ns_a1;
            cs_a2  <= ns_a2;
            // set on entry, drops by itself
            hold_1 <= gate_1 & ~hold_1;
            hold_2 <= gate_2 & ~hold_2;
        end
    end

    // steps that wait one extra cycle
    always_comb begin
        case (sc)
            shift_0: gate_1 = (cs_a1 == a1_2e2) || (cs_a1 == a1_e2_2e3);
            shift_2: gate_1 = (cs_a1 == a1_5e1_2e3) || (cs_a1 == a1_e2_2e3);
            default: gate_1 = 1'b0;
        endcase
        gate_2 = (sc != shift_0) && (cs_a2 == a2_2e1_e3);
    end

    always_comb begin
        ns_a1 = a1_idle;
        ns_a2 = a2_idle;
        case (sc)
            shift_0: begin
                case (cs_a1)
                    a1_idle:   ns_a1 = est.e2_ready ? a1_e2 : a1_idle;
                    a1_e2:     ns_a1 = a1_2e2;
                    a1_2e2:    ns_a1 = hold_1 ? a1_e2_2e3 : a1_2e2;
                    a1_e2_2e3: ns_a1 = hold_1 ? a1_e2_2e4 : a1_e2_2e3;
                    a1_e2_2e4: ns_a1 = a1_2e2_5e4;
                    default:   ns_a1 = a1_idle;
                endcase
                case (cs_a2)
                    a2_idle:   ns_a2 = est.e3_ready ? a2_2e1_e3 : a2_idle;
                    a2_2e1_e3: ns_a2 = a2_e1_2e3;
                    a2_e1_2e3: ns_a2 = a2_2e2_e3;
                    a2_2e2_e3: ns_a2 = a2_2e2_e4;
                    a2_2e2_e4: ns_a2 = a2_5e4;
                    a2_5e4:    ns_a2 = a2_4e4_e2;
                    default:   ns_a2 = a2_idle;
                endcase
            end
            shift_1: begin
                // adder 1 trails adder 2 here
                case (cs_a1)
                    a1_idle:   ns_a1 = (cs_a2 == a2_4e1_e3) ? a1_2e3_e1 : a1_idle;
                    a1_2e3_e1: ns_a1 = a1_e2_2e3;
                    a1_e2_2e3: ns_a1 = a1_e2;
                    a1_e2:     ns_a1 = a1_e2_2e4;
                    default:   ns_a1 = a1_idle;
                endcase
                case (cs_a2)
                    a2_idle:   ns_a2 = est.e3_ready ? a2_e3 : a2_idle;
                    a2_e3:     ns_a2 = a2_4e1_e3;
                    a2_4e1_e3: ns_a2 = a2_2e1_e3;
                    a2_2e1_e3: ns_a2 = hold_2 ? a2_2e2_e3 : a2_2e1_e3;
                    a2_2e2_e3: ns_a2 = a2_2e2_e4;
                    a2_2e2_e4: ns_a2 = a2_4e4_e2;
                    default:   ns_a2 = a2_idle;
                endcase
            end
            default: begin
                case (cs_a1)
                    a1_idle:    ns_a1 = est.e3_ready ? a1_2e3 : a1_idle;
                    a1_2e3:     ns_a1 = a1_5e1_2e3;
                    a1_5e1_2e3: ns_a1 = hold_1 ? a1_2e3_e1 : a1_5e1_2e3;
                    a1_2e3_e1:  ns_a1 = a1_e2_2e3;
                    a1_e2_2e3:  ns_a1 = hold_1 ? a1_e2_2e4 : a1_e2_2e3;
                    default:    ns_a1 = a1_idle;
                endcase
                // adder 2 starts a cycle early on e2
                case (cs_a2)
                    a2_idle:   ns_a2 = est.e2_ready ? a2_5e1 : a2_idle;
                    a2_5e1:    ns_a2 = a2_e3;
                    a2_e3:     ns_a2 = a2_4e1_e3;
                    a2_4e1_e3: ns_a2 = a2_2e1_e3;
                    a2_2e1_e3: ns_a2 = hold_2 ? a2_2e2_e3 : a2_2e1_e3;
                    a2_2e2_e3: ns_a2 = a2_2e2_e4;
                    default:   ns_a2 = a2_idle;
                endcase
            end
        endcase
    end

    // ==================================================================
    // adder mux selects, 7 parks both operands
    // ==================================================================

    always_comb begin
        case (cs_a1)
            a1_e2:      {s1a, s1b} = 6'b000_000;
            a1_2e2:     {s1a, s1b} = 6'b001_000;
            a1_e2_2e3:  {s1a, s1b} = 6'b011_001;
            a1_e2_2e4:  {s1a, s1b} = 6'b011_011;
            a1_2e2_5e4: {s1a, s1b} = 6'b010_010;
            a1_2e3_e1:  {s1a, s1b} = 6'b110_110;
            a1_2e3:     {s1a, s1b} = 6'b100_000;
            a1_5e1_2e3: {s1a, s1b} = 6'b101_100;
            default:    {s1a, s1b} = 6'b111_111;
        endcase
        case (cs_a2)
            a2_2e1_e3: {s2a, s2b} = 6'b000_000;
            a2_e1_2e3: {s2a, s2b} = 6'b001_001;
            a2_2e2_e3: {s2a, s2b} = 6'b011_000;
            a2_2e2_e4: {s2a, s2b} = 6'b011_011;
            a2_5e4:    {s2a, s2b} = 6'b010_011;
            a2_4e4_e2: {s2a, s2b} = 6'b010_010;
            a2_e3:     {s2a, s2b} = 6'b110_110;
            a2_4e1_e3: {s2a, s2b} = 6'b100_100;
            a2_5e1:    {s2a, s2b} = 6'b001_100;
            default:   {s2a, s2b} = 6'b111_111;
        endcase
    end

    // register enables fire in the step after the value is formed
    assign en_reg_e  = (sc == shift_0 && cs_a2 == a2_2e1_e3)
                     || (sc == shift_1 && cs_a1 == a1_e2_2e4)
                     || (sc == shift_2 && cs_a2 == a2_4e1_e3);
    // shift_1 stores -e3 here
    assign en_reg_2e = (sc == shift_0 && cs_a2 == a2_e1_2e3)
                     || (sc != shift_0 && cs_a2 == a2_4e1_e3);
    assign en_reg_5e = (sc == shift_0 && cs_a2 == a2_4e4_e2)
                     || (sc == shift_2 && cs_a2 == a2_e3);

    // ==================================================================
    // output stage control
    // ==================================================================

    assign octl.load_sel    = (sc == shift_0 && cs_a1 == a1_e2) || (cs_a2 == a2_e3);
    assign octl.valid_start = (sc == shift_0) ? (cs_a2 == a2_2e1_e3) : (cs_a2 == a2_4e1_e3);
    // adder 1 finishes last only for shift_2
    assign octl.valid_end   = (sc == shift_2) ? (cs_a1 != a1_idle && ns_a1 == a1_idle)
                                              : (cs_a2 != a2_idle && ns_a2 == a2_idle);
    assign octl.shift_class = sc;

    assign en_vec = {en_reg_e, en_reg_2e, en_reg_5e};

    // no enable held two cycles in a row
    assert property (@(posedge clk) disable iff (!rst) (en_vec & $past(en_vec)) == 3'b000)
        else $error("register enable longer than one cycle");

    // adder start timing relies on back-to-back strobes
    assert property (@(posedge clk) disable iff (!rst)
                     est.e1_ready |=> est.e2_ready ##1 est.e3_ready)
        else $error("estimate ready strobes out of order");

endmodule

// File: h_select_sequencer.sv
`timescale 1ns/1ps
`include "ch_est_defines.svh"

module h_select_sequencer
    import ch_est_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    out_ctl_if.sink    octl,
    output logic [1:0] s_h1,
    output logic [1:0] s_h2,
    output logic       s_est,
    output logic       valid_eqlz
);

    sel_seq_t seq_h1, seq_h2;
    // forced shift right after the load
    logic     shift_once;

    // ==================================================================
    // select sequence registers
    // ==================================================================

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            seq_h1     <= '0;
            seq_h2     <= '0;
            shift_once <= 1'b0;
        end else begin
            shift_once <= octl.load_sel;
            if (octl.load_sel) begin
                seq_h1 <= sel_seq_h1[octl.shift_class];
                seq_h2 <= sel_seq_h2[octl.shift_class];
            end else if (shift_once || valid_eqlz) begin
                // one 2-bit field per step
                seq_h1 <= seq_h1 >> 2;
                seq_h2 <= seq_h2 >> 2;
            end
        end
    end

    assign s_h1 = seq_h1[1:0];
    assign s_h2 = seq_h2[1:0];

    // shift_1 feeds e3/e4 to out mux 1 and e1/e2 to out mux 2
    assign s_est = (octl.shift_class == shift_1);

    // equalizer data window
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_eqlz <= 1'b0;
        end else if (octl.valid_end) begin
            valid_eqlz <= 1'b0;
        end else if (octl.valid_start) begin
            valid_eqlz <= 1'b1;
        end
    end

    // window always opens on a freshly loaded sequence
    assert property (@(posedge clk) disable iff (!rst)
                     $rose(valid_eqlz) |-> $past(octl.load_sel, 2))
        else $error("valid_eqlz rose without a select load");

endmodule

// File: ch_est_cntrl_unit.sv
`timescale 1ns/1ps
`include "ch_est_defines.svh"

module ch_est_cntrl_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      demap_ready,
    input  logic                      nrs_gen_ready,
    input  logic [2:0]                v_shift,
    output logic [3:0]                col,
    output logic [1:0]                nrs_index_addr,
    output logic                      demap_read,
    output logic [`CE_NRS_ADDR_W-1:0] rd_addr_nrs,
    output logic [1:0]                addr_mem,
    output logic                      mult_mem_en,
    output logic                      avg_mem_en,
    output logic                      en_reg_e,
    output logic                      en_reg_2e,
    output logic                      en_reg_5e,
    output logic [`CE_SEL_W-1:0]      s1a,
    output logic [`CE_SEL_W-1:0]      s1b,
    output logic [`CE_SEL_W-1:0]      s2a,
    output logic [`CE_SEL_W-1:0]      s2b,
    output logic [1:0]                s_h1,
    output logic [1:0]                s_h2,
    output logic                      s_est,
    output logic                      valid_eqlz
);

    est_if     i_est_if ();
    out_ctl_if i_out_ctl_if ();

    // ==================================================================
    // pilot reads, memory enables, shift decode
    // ==================================================================

    slot_sequencer i_slot_sequencer (
        .clk            (clk),
        .rst            (rst),
        .demap_ready    (demap_ready),
        .nrs_gen_ready  (nrs_gen_ready),
        .v_shift        (v_shift),
        .col            (col),
        .nrs_index_addr (nrs_index_addr),
        .rd_addr_nrs    (rd_addr_nrs),
        .addr_mem       (addr_mem),
        .demap_read     (demap_read),
        .mult_mem_en    (mult_mem_en),
        .avg_mem_en     (avg_mem_en),
        .est            (i_est_if.source)
    );

    // adder sequencing and register enables
    interp_sequencer i_interp_sequencer (
        .clk       (clk),
        .rst       (rst),
        .est       (i_est_if.sink),
        .octl      (i_out_ctl_if.source),
        .s1a       (s1a),
        .s1b       (s1b),
        .s2a       (s2a),
        .s2b       (s2b),
        .en_reg_e  (en_reg_e),
        .en_reg_2e (en_reg_2e),
        .en_reg_5e (en_reg_5e)
    );

    // out mux sequences and valid window
    h_select_sequencer i_h_select_sequencer (
        .clk        (clk),
        .rst        (rst),
        .octl       (i_out_ctl_if.sink),
        .s_h1       (s_h1),
        .s_h2       (s_h2),
        .s_est      (s_est),
        .valid_eqlz (valid_eqlz)
    );

endmodule

// File: tb_ch_est_cntrl_unit.sv
`timescale 1ns/1ps
`include "ch_est_defines.svh"

module tb_ch_est_cntrl_unit;

    localparam int          clk_period      = 8;
    localparam int          num_slots       = 10;
    localparam int          line_len        = 9;
    localparam int          max_pairs       = 6;
    localparam int          cycles_per_slot = 60;
    localparam logic [31:0] rng_seed        = 32'd22;
    // demap pilot columns with two reads each
    localparam int          col_table [4]   = '{5, 6, 12, 13};

    // error classes
    localparam int k_timing = 0;
    localparam int k_addr   = 1;
    localparam int k_out    = 2;
    localparam int k_stim   = 3;

    logic                      clk;
    logic                      rst;
    logic                      demap_ready;
    logic                      nrs_gen_ready;
    logic [2:0]                v_shift;
    logic [3:0]                col;
    logic [1:0]                nrs_index_addr;
    logic                      demap_read;
    logic [`CE_NRS_ADDR_W-1:0] rd_addr_nrs;
    logic [1:0]                addr_mem;
    logic                      mult_mem_en;
    logic                      avg_mem_en;
    logic                      en_reg_e;
    logic                      en_reg_2e;
    logic                      en_reg_5e;
    logic [`CE_SEL_W-1:0]      s1a;
    logic [`CE_SEL_W-1:0]      s1b;
    logic [`CE_SEL_W-1:0]      s2a;
    logic [`CE_SEL_W-1:0]      s2b;
    logic [1:0]                s_h1;
    logic [1:0]                s_h2;
    logic                      s_est;
    logic                      valid_eqlz;

    // per slot v_shift, gap, valid length and six s_h1/s_h2 pairs
    logic [7:0]  stim [num_slots*line_len];
    logic [31:0] rng_state;
    int          errs [4];
    int          checks;
    int          cur_slot;
    int          nrs_addr_model;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;

    ch_est_cntrl_unit i_ch_est_cntrl_unit (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ==================================================================
    // helpers
    // ==================================================================

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // v_shift 0/3 -> 0, 1/4 -> 1, others -> 2
    function automatic int decode_shift(input int vs);
        if (vs == 0 || vs == 3) begin
            return 0;
        end
        if (vs == 1 || vs == 4) begin
            return 1;
        end
        return 2;
    endfunction

    task automatic check_eq(input int got, input int exp, input string what, input int kind);
        checks++;
        assert (got == exp) else begin
            errs[kind]++;
            $display("Error at %0d ns: slot %0d: %s is %0d, expected %0d",
                     $time, cur_slot, what, got, exp);
        end
    endtask

    // single-cycle pulse and none after the window closed
    task automatic track_pulse(input logic now, input bit prev, input bit late,
                               input string what, inout int cnt);
        if (now) begin
            cnt++;
            checks += 2;
            assert (!prev) else begin
                errs[k_timing]++;
                $display("Error at %0d ns: slot %0d: %s high for more than one cycle",
                         $time, cur_slot, what);
            end
            assert (!late) else begin
                errs[k_timing]++;
                $display("Error at %0d ns: slot %0d: %s pulsed after valid_eqlz fell",
                         $time, cur_slot, what);
            end
        end
    endtask

    task automatic load_stimulus();
        int bad;
        // fill marks lines the file did not provide
        foreach (stim[i]) begin
            stim[i] = 8'hc0 ^ 8'(i);
        end
        $readmemh("stimulus_slots.txt", stim);
        bad = 0;
        for (int s = 0; s < num_slots; s++) begin
            if (stim[s * line_len] > 8'd7) begin
                bad++;
            end
        end
        checks++;
        assert (bad == 0) else begin
            errs[k_stim]++;
            $display("stimulus_slots.txt is missing or has %0d unusable slot lines", bad);
        end
    endtask

    task automatic check_idle_outputs();
        check_eq(int'(demap_read), 0, "demap_read after reset", k_timing);
        check_eq(int'(mult_mem_en), 0, "mult_mem_en after reset", k_timing);
        check_eq(int'(avg_mem_en), 0, "avg_mem_en after reset", k_timing);
        check_eq(int'({en_reg_e, en_reg_2e, en_reg_5e}), 0, "register enables", k_timing);
        check_eq(int'(valid_eqlz), 0, "valid_eqlz after reset", k_timing);
        check_eq(int'({s1a, s1b, s2a, s2b}), 12'hfff, "adder selects after reset", k_out);
    endtask

    // ==================================================================
    // one slot sampled on the falling edge
    // ==================================================================

    task automatic run_slot(input int slot);
        int         base;
        int         sc;
        int         linger;
        int         c;
        int         r;
        int         in_win;
        int         vlen;
        int         rises;
        int         n_e;
        int         n_2e;
        int         n_5e;
        bit         add_slot;
        bit         prev_valid;
        bit         prev_e;
        bit         prev_2e;
        bit         prev_5e;
        bit         win_done;
        bit         mem_seen;
        bit         mem_done;
        logic [7:0] pair;
        base       = slot * line_len;
        cur_slot   = slot;
        // store slot first after reset and alternating after that
        add_slot   = (slot % 2) == 1;
        sc         = decode_shift(int'(stim[base]));
        linger     = int'(next_random() % 32'd5);
        c          = 0;
        vlen       = 0;
        rises      = 0;
        n_e        = 0;
        n_2e       = 0;
        n_5e       = 0;
        prev_valid = 1'b0;
        prev_e     = 1'b0;
        prev_2e    = 1'b0;
        prev_5e    = 1'b0;
        win_done   = 1'b0;
        mem_seen   = 1'b0;
        mem_done   = 1'b0;
        repeat (int'(stim[base + 1])) begin
            @(posedge clk);
            #1;
        end
        v_shift       = stim[base][2:0];
        demap_ready   = 1'b1;
        nrs_gen_ready = 1'b1;
        while (!(mem_done && (win_done || !add_slot))) begin
            @(negedge clk);
            check_eq(int'(demap_read), int'(c >= 1 && c <= 4), "demap_read", k_timing);
            if (c >= 1 && c <= 4) begin
                r = c - 1;
                check_eq(int'(col), col_table[(2 * slot + r / 2) % 4], "col", k_addr);
                check_eq(int'(nrs_index_addr), r, "nrs_index_addr", k_addr);
                check_eq(int'(addr_mem), r, "addr_mem", k_addr);
                check_eq(int'(rd_addr_nrs), nrs_addr_model, "rd_addr_nrs", k_addr);
                nrs_addr_model = (nrs_addr_model + 2) % (1 << `CE_NRS_ADDR_W);
            end
            // memory enable one cycle behind the reads
            in_win = int'(c >= 2 && c <= 5);
            check_eq(int'(mult_mem_en), add_slot ? 0 : in_win, "mult_mem_en", k_timing);
            check_eq(int'(avg_mem_en), add_slot ? in_win : 0, "avg_mem_en", k_timing);
            check_eq(int'(mult_mem_en && avg_mem_en), 0, "both memory enables", k_timing);
            if (mult_mem_en || avg_mem_en) begin
                mem_seen = 1'b1;
            end else if (mem_seen) begin
                mem_done = 1'b1;
            end
            check_eq(int'(s_est), int'(sc == 1), "s_est", k_out);
            track_pulse(en_reg_e, prev_e, win_done, "en_reg_e", n_e);
            track_pulse(en_reg_2e, prev_2e, win_done, "en_reg_2e", n_2e);
            track_pulse(en_reg_5e, prev_5e, win_done, "en_reg_5e", n_5e);
            if (valid_eqlz) begin
                if (!prev_valid) begin
                    rises++;
                end
                if (vlen < max_pairs) begin
                    pair = stim[base + 3 + vlen];
                    check_eq(int'(s_h1), int'(pair[7:4]), "s_h1", k_out);
                    check_eq(int'(s_h2), int'(pair[3:0]), "s_h2", k_out);
                end
                vlen++;
            end else if (prev_valid) begin
                win_done = 1'b1;
                check_eq(int'(s1a), 7, "s1a after window", k_out);
                check_eq(int'(s1b), 7, "s1b after window", k_out);
                check_eq(int'(s2a), 7, "s2a after window", k_out);
                check_eq(int'(s2b), 7, "s2b after window", k_out);
            end
            prev_valid = valid_eqlz;
            prev_e     = en_reg_e;
            prev_2e    = en_reg_2e;
            prev_5e    = en_reg_5e;
            @(posedge clk);
            #1;
            // readies linger into the busy cycles
            if (c == linger) begin
                demap_ready   = 1'b0;
                nrs_gen_ready = 1'b0;
            end
            c++;
        end
        check_eq(rises, add_slot ? 1 : 0, "valid_eqlz rises", k_timing);
        check_eq(vlen, int'(stim[base + 2]), "valid_eqlz length", k_timing);
        check_eq(n_e, add_slot ? 1 : 0, "en_reg_e pulses", k_timing);
        check_eq(n_2e, add_slot ? 1 : 0, "en_reg_2e pulses", k_timing);
        check_eq(n_5e, (add_slot && sc != 1) ? 1 : 0, "en_reg_5e pulses", k_timing);
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================

    initial begin
        int gaps;
        int total;
        rst            = 1'b0;
        demap_ready    = 1'b0;
        nrs_gen_ready  = 1'b0;
        v_shift        = 3'd0;
        rng_state      = rng_seed;
        checks         = 0;
        cur_slot       = -1;
        nrs_addr_model = 0;
        foreach (errs[k]) begin
            errs[k] = 0;
        end
        load_stimulus();
        gaps = 0;
        for (int s = 0; s < num_slots; s++) begin
            gaps += int'(stim[s * line_len + 1]);
        end
        cycle_limit = 10 + gaps + cycles_per_slot * num_slots;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        @(posedge clk);
        #1;
        if (errs[k_stim] == 0) begin
            for (int s = 0; s < num_slots; s++) begin
                run_slot(s);
            end
        end
        total = errs[k_timing] + errs[k_addr] + errs[k_out] + errs[k_stim];
        $display("checks %0d, errors: timing %0d, address %0d, output %0d, stimulus %0d",
                 checks, errs[k_timing], errs[k_addr], errs[k_out], errs[k_stim]);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: stimulus_slots.txt
// v_shift, idle gap, valid length, then six s_h1/s_h2 pairs (high digit s_h1, low s_h2)
// one slot per line, store and add slots alternate from the first line
03 02 00 00 00 00 00 00 00
00 01 05 11 30 20 33 12 00
04 03 00 00 00 00 00 00 00
01 00 05 12 02 13 32 20 00
06 02 00 00 00 00 00 00 00
05 04 05 00 31 30 22 13 00
00 01 00 00 00 00 00 00 00
04 02 05 12 02 13 32 20 00
07 00 00 00 00 00 00 00 00
03 01 05 11 30 20 33 12 00

// File: files.f
+incdir+.
ch_est_pkg.sv
ch_est_ifs.sv
slot_sequencer.sv
interp_sequencer.sv
h_select_sequencer.sv
ch_est_cntrl_unit.sv
tb_ch_est_cntrl_unit.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_ch_est_cntrl_unit
FILELIST  := files.f
OBJ_DIR   := obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) stimulus_slots.txt
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
